// File: hw/hacd_config.svh
/* Build-time sizing of the accelerator, shared by both packages and the testbench
   Page geometry is changed here and every derived type follows */
`ifndef HACD_CONFIG_SVH
`define HACD_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// Bus widths
//////////////////////////////////////////////////////////////////////

// CPU and memory controller address
`define HACD_ADDR_W 32
// Write data, also the register bus data
`define HACD_DATA_W 32

//////////////////////////////////////////////////////////////////////
// Page geometry
//////////////////////////////////////////////////////////////////////

// 4 KiB pages
`define HACD_PAGE_SHIFT 12
// Pages covered by the use bitmap
`define HACD_NUM_PAGES 16
// Must stay log2 of HACD_NUM_PAGES
`define HACD_PAGE_IDX_W 4

`endif

// File: hw/hacd_reg_pkg.sv
/* Register map of the accelerator with the bus types, offsets and bit positions
   Imported by the register block, the top level and the testbench */
`include "hacd_config.svh"

package hacd_reg_pkg;

  //////////////////////////////////////////////////////////////////////
  // Register bus payload
  //////////////////////////////////////////////////////////////////////

  // Byte address on the register bus
  typedef logic [`HACD_ADDR_W-1:0] reg_addr_t;
  // Read and write data
  typedef logic [`HACD_DATA_W-1:0] reg_data_t;

  //////////////////////////////////////////////////////////////////////
  // Register offsets
  //////////////////////////////////////////////////////////////////////

  // Control, read-write
  localparam reg_addr_t OFS_CTRL   = 'h0;
  // Low watermark in pages, read-write
  localparam reg_addr_t OFS_LOW_WM = 'h4;
  // Free count and inflate flag, flag is write-one-to-clear
  localparam reg_addr_t OFS_STATUS = 'h8;

  // Control bits
  // Inflate interrupt enable
  localparam int unsigned CTRL_INFL_EN = 0;
  // Deflate interrupt enable
  localparam int unsigned CTRL_DEFL_EN = 1;
  // Dump command, reads back as 0
  localparam int unsigned CTRL_DUMP    = 2;

  // Status fields
  // Free page count sits in the low bits
  localparam int unsigned STAT_CNT_W    = 16;
  // Sticky inflate-pending flag
  localparam int unsigned STAT_INFL_BIT = 16;

endpackage

// File: hw/hacd_mem_pkg.sv
/* Memory-side types of the accelerator for the CPU and memory controller channels
   Also gives the page lookup used by the page tracker */
`include "hacd_config.svh"

package hacd_mem_pkg;

  //////////////////////////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////////////////////////

  typedef logic [`HACD_ADDR_W-1:0] mem_addr_t;
  typedef logic [`HACD_DATA_W-1:0] mem_data_t;

  // Write channel item, address in the upper bits
  typedef struct packed {
    mem_addr_t addr;
    mem_data_t data;
  } mem_wr_t;

  //////////////////////////////////////////////////////////////////////
  // Page bookkeeping
  //////////////////////////////////////////////////////////////////////

  // Index into the use bitmap
  typedef logic [`HACD_PAGE_IDX_W-1:0] page_idx_t;
  // Page counter, matches the status count field
  typedef logic [15:0] page_cnt_t;

  // Page of an address
  // Bits above the tracked window are ignored
  function automatic page_idx_t page_of(mem_addr_t addr);
    return addr[`HACD_PAGE_SHIFT +: `HACD_PAGE_IDX_W];
  endfunction

endpackage

// File: hw/hacd_regs.sv
/* Register block behind the register bus with control, watermark and status
   The dump bit leaves as a one-cycle pulse and the inflate flag stays until cleared */
module hacd_regs (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Register bus, always ready
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  hacd_reg_pkg::reg_addr_t reg_addr_i,
  input  hacd_reg_pkg::reg_data_t reg_wdata_i,
  output hacd_reg_pkg::reg_data_t reg_rdata_o,
  output logic                    reg_error_o,
  // Live state from the core
  input  hacd_mem_pkg::page_cnt_t free_cnt_i,
  input  logic                    infl_miss_i,
  // Register outputs
  output hacd_reg_pkg::reg_data_t ctrl_q_o,
  output hacd_reg_pkg::reg_data_t low_wm_q_o,
  output logic                    infl_pend_o,
  output logic                    dump_pulse_o
);

  import hacd_reg_pkg::*;

  reg_data_t ctrl_q;
  reg_data_t low_wm_q;
  logic      infl_pend_q;
  logic      dump_q;

  // Decode results
  logic      ctrl_we;
  logic      low_wm_we;
  logic      infl_clr;
  reg_data_t ctrl_wdata;

  //////////////////////////////////////////////////////////////////////
  // Bus decode
  //////////////////////////////////////////////////////////////////////

  // Reads answer in the same cycle
  always_comb begin
    reg_rdata_o = '0;
    reg_error_o = 1'b0;
    ctrl_we     = 1'b0;
    low_wm_we   = 1'b0;
    infl_clr    = 1'b0;
    if (reg_valid_i) begin
      case (reg_addr_i)
        OFS_CTRL: begin
          if (reg_write_i) begin
            ctrl_we = 1'b1;
          end else begin
            reg_rdata_o = ctrl_q;
          end
        end
        OFS_LOW_WM: begin
          if (reg_write_i) begin
            low_wm_we = 1'b1;
          end else begin
            reg_rdata_o = low_wm_q;
          end
        end
        OFS_STATUS: begin
          // Only the inflate flag is writable here
          if (reg_write_i) begin
            infl_clr = reg_wdata_i[STAT_INFL_BIT];
          end else begin
            reg_rdata_o[STAT_CNT_W-1:0] = free_cnt_i;
            reg_rdata_o[STAT_INFL_BIT]  = infl_pend_q;
          end
        end
        // Unmapped, error and no side effect
        default: reg_error_o = 1'b1;
      endcase
    end
  end

  // Dump is a command, never kept in the register
  always_comb begin
    ctrl_wdata            = reg_wdata_i;
    ctrl_wdata[CTRL_DUMP] = 1'b0;
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q   <= '0;
      low_wm_q <= '0;
      dump_q   <= 1'b0;
    end else begin
      // Self-clearing, high for one cycle per write
      dump_q <= ctrl_we & reg_wdata_i[CTRL_DUMP];
      if (ctrl_we) begin
        ctrl_q <= ctrl_wdata;
      end
      if (low_wm_we) begin
        low_wm_q <= reg_wdata_i;
      end
    end
  end

  // Sticky inflate flag
  // A new miss beats a clear in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      infl_pend_q <= 1'b0;
    end else if (infl_miss_i) begin
      infl_pend_q <= 1'b1;
    end else if (infl_clr) begin
      infl_pend_q <= 1'b0;
    end
  end

  assign ctrl_q_o     = ctrl_q;
  assign low_wm_q_o   = low_wm_q;
  assign infl_pend_o  = infl_pend_q;
  assign dump_pulse_o = dump_q;

endmodule

// File: hw/hacd_page_tracker.sv
/* Page-use bitmap and free-page counter fed by the observed CPU strobes
   Flags reads of pages that no write has touched since reset or the last dump */
`include "hacd_config.svh"

module hacd_page_tracker (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Observed CPU writes
  input  logic                    wr_valid_i,
  input  hacd_mem_pkg::mem_addr_t wr_addr_i,
  // Observed CPU reads
  input  logic                    rd_valid_i,
  input  hacd_mem_pkg::mem_addr_t rd_addr_i,
  // Dump, empties the bitmap
  input  logic                    clear_i,
  output hacd_mem_pkg::page_cnt_t free_cnt_o,
  output logic                    miss_o
);

  import hacd_mem_pkg::*;

  // Counter value with every page free
  localparam page_cnt_t ALL_FREE = page_cnt_t'(`HACD_NUM_PAGES);

  // One bit per page, set on first write
  logic [`HACD_NUM_PAGES-1:0] used_q;
  page_cnt_t                  free_cnt_q;

  page_idx_t wr_page;
  page_idx_t rd_page;
  logic      first_touch;

  //////////////////////////////////////////////////////////////////////
  // Page lookup
  //////////////////////////////////////////////////////////////////////

  assign wr_page = page_of(wr_addr_i);
  assign rd_page = page_of(rd_addr_i);

  // Write to a page not yet in use
  assign first_touch = wr_valid_i & ~used_q[wr_page];

  // Read of an unused page
  // Seen in the cycle of the strobe
  assign miss_o = rd_valid_i & ~used_q[rd_page];

  //////////////////////////////////////////////////////////////////////
  // Bitmap and counter
  //////////////////////////////////////////////////////////////////////

  // Counter tracks the bitmap so no popcount is needed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      used_q     <= '0;
      free_cnt_q <= ALL_FREE;
    end else if (clear_i) begin
      // Dump wins over a write in the same cycle
      used_q     <= '0;
      free_cnt_q <= ALL_FREE;
    end else if (first_touch) begin
      used_q[wr_page] <= 1'b1;
      free_cnt_q      <= free_cnt_q - page_cnt_t'(1);
    end
  end

  assign free_cnt_o = free_cnt_q;

endmodule

// File: hw/hacd_fwd_stage.sv
/* One-cycle forwarding register between the CPU side and the memory controller
   The payload type is a parameter so one stage serves reads and writes */
module hacd_fwd_stage #(
  parameter type payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  logic     valid_q;
  payload_t data_q;

  // Strobe delayed by exactly one cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= valid_i;
    end
  end

  // Payload only moves with a valid item
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      data_q <= data_i;
    end
  end

  assign valid_o = valid_q;
  assign data_o  = data_q;

endmodule

// File: hw/hacd_core.sv
/* Core of the accelerator, forwards CPU traffic to the memory controller
   and lets the page tracker watch the same strobes */
module hacd_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // CPU write channel
  input  logic                    cpu_wr_valid_i,
  input  hacd_mem_pkg::mem_addr_t cpu_wr_addr_i,
  input  hacd_mem_pkg::mem_data_t cpu_wr_data_i,
  // CPU read channel
  input  logic                    cpu_rd_valid_i,
  input  hacd_mem_pkg::mem_addr_t cpu_rd_addr_i,
  // Memory controller write channel
  output logic                    mc_wr_valid_o,
  output hacd_mem_pkg::mem_addr_t mc_wr_addr_o,
  output hacd_mem_pkg::mem_data_t mc_wr_data_o,
  // Memory controller read channel
  output logic                    mc_rd_valid_o,
  output hacd_mem_pkg::mem_addr_t mc_rd_addr_o,
  // Dump pulse from the registers
  input  logic                    dump_i,
  output hacd_mem_pkg::page_cnt_t free_cnt_o,
  output logic                    infl_miss_o
);

  import hacd_mem_pkg::*;

  mem_wr_t wr_in;
  mem_wr_t wr_out;

  //////////////////////////////////////////////////////////////////////
  // Forwarding
  //////////////////////////////////////////////////////////////////////

  // Address and data travel together through the write stage
  assign wr_in = '{addr: cpu_wr_addr_i, data: cpu_wr_data_i};

  hacd_fwd_stage #(.payload_t(mem_wr_t)) u_wr_stage (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (cpu_wr_valid_i),
    .data_i  (wr_in),
    .valid_o (mc_wr_valid_o),
    .data_o  (wr_out)
  );

  assign mc_wr_addr_o = wr_out.addr;
  assign mc_wr_data_o = wr_out.data;

  // Read side carries the address only
  hacd_fwd_stage #(.payload_t(mem_addr_t)) u_rd_stage (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (cpu_rd_valid_i),
    .data_i  (cpu_rd_addr_i),
    .valid_o (mc_rd_valid_o),
    .data_o  (mc_rd_addr_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Page tracking
  //////////////////////////////////////////////////////////////////////

  // Watches the CPU side, before the stages
  hacd_page_tracker u_page_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wr_valid_i (cpu_wr_valid_i),
    .wr_addr_i  (cpu_wr_addr_i),
    .rd_valid_i (cpu_rd_valid_i),
    .rd_addr_i  (cpu_rd_addr_i),
    .clear_i    (dump_i),
    .free_cnt_o (free_cnt_o),
    .miss_o     (infl_miss_o)
  );

endmodule

// File: hw/hacd.sv
/* Top level of the accelerator in front of the memory controller
   Connects the register block and the core and forms both interrupts */
module hacd (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // Register bus
  input  logic                    reg_valid_i,
  input  logic                    reg_write_i,
  input  hacd_reg_pkg::reg_addr_t reg_addr_i,
  input  hacd_reg_pkg::reg_data_t reg_wdata_i,
  output hacd_reg_pkg::reg_data_t reg_rdata_o,
  output logic                    reg_error_o,
  // CPU side
  input  logic                    cpu_wr_valid_i,
  input  hacd_mem_pkg::mem_addr_t cpu_wr_addr_i,
  input  hacd_mem_pkg::mem_data_t cpu_wr_data_i,
  input  logic                    cpu_rd_valid_i,
  input  hacd_mem_pkg::mem_addr_t cpu_rd_addr_i,
  // Memory controller side
  output logic                    mc_wr_valid_o,
  output hacd_mem_pkg::mem_addr_t mc_wr_addr_o,
  output hacd_mem_pkg::mem_data_t mc_wr_data_o,
  output logic                    mc_rd_valid_o,
  output hacd_mem_pkg::mem_addr_t mc_rd_addr_o,
  // Interrupts and dump request
  output logic                    infl_irq_o,
  output logic                    defl_irq_o,
  output logic                    dump_mem_o
);

  import hacd_reg_pkg::*;
  import hacd_mem_pkg::*;

  reg_data_t ctrl_q;
  reg_data_t low_wm_q;
  logic      infl_pend;
  logic      dump_pulse;
  page_cnt_t free_cnt;
  logic      infl_miss;

  hacd_regs u_hacd_regs (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .reg_valid_i  (reg_valid_i),
    .reg_write_i  (reg_write_i),
    .reg_addr_i   (reg_addr_i),
    .reg_wdata_i  (reg_wdata_i),
    .reg_rdata_o  (reg_rdata_o),
    .reg_error_o  (reg_error_o),
    .free_cnt_i   (free_cnt),
    .infl_miss_i  (infl_miss),
    .ctrl_q_o     (ctrl_q),
    .low_wm_q_o   (low_wm_q),
    .infl_pend_o  (infl_pend),
    .dump_pulse_o (dump_pulse)
  );

  hacd_core u_hacd_core (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .cpu_wr_valid_i (cpu_wr_valid_i),
    .cpu_wr_addr_i  (cpu_wr_addr_i),
    .cpu_wr_data_i  (cpu_wr_data_i),
    .cpu_rd_valid_i (cpu_rd_valid_i),
    .cpu_rd_addr_i  (cpu_rd_addr_i),
    .mc_wr_valid_o  (mc_wr_valid_o),
    .mc_wr_addr_o   (mc_wr_addr_o),
    .mc_wr_data_o   (mc_wr_data_o),
    .mc_rd_valid_o  (mc_rd_valid_o),
    .mc_rd_addr_o   (mc_rd_addr_o),
    .dump_i         (dump_pulse),
    .free_cnt_o     (free_cnt),
    .infl_miss_o    (infl_miss)
  );

  //////////////////////////////////////////////////////////////////////
  // Interrupts
  //////////////////////////////////////////////////////////////////////

  // Free pages strictly below the watermark
  assign defl_irq_o = ctrl_q[CTRL_DEFL_EN] & (reg_data_t'(free_cnt) < low_wm_q);
  // Pending inflate request
  assign infl_irq_o = ctrl_q[CTRL_INFL_EN] & infl_pend;
  assign dump_mem_o = dump_pulse;

endmodule

// File: verification/hacd_tb.sv
/* Self-checking testbench for the accelerator top level
   Applies a table of register and CPU operations and checks against a reference model */
`include "hacd_config.svh"

module hacd_tb;

  import hacd_reg_pkg::*;
  import hacd_mem_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // Table format
  //////////////////////////////////////////////////////////////////////

  localparam logic [2:0] OP_IDLE   = 3'd0;
  localparam logic [2:0] OP_REG_WR = 3'd1;
  localparam logic [2:0] OP_REG_RD = 3'd2;
  localparam logic [2:0] OP_CPU_WR = 3'd3;
  localparam logic [2:0] OP_CPU_RD = 3'd4;
  // Register write to control followed by a wait for the dump pulse
  localparam logic [2:0] OP_DUMP   = 3'd5;

  // Cycles allowed for the dump pulse to show up
  localparam int unsigned DUMP_WAIT_MAX = 8;

  typedef struct packed {
    logic [2:0] op;
    reg_addr_t  addr;  // Register offset or page base for CPU ops
    reg_data_t  data;
    reg_data_t  exp;   // Expected read data
    logic       err;   // Expected reg_error_o
  } step_t;

  logic      clk_i;
  logic      rst_ni;
  logic      reg_valid_i;
  logic      reg_write_i;
  reg_addr_t reg_addr_i;
  reg_data_t reg_wdata_i;
  reg_data_t reg_rdata_o;
  logic      reg_error_o;
  logic      cpu_wr_valid_i;
  mem_addr_t cpu_wr_addr_i;
  mem_data_t cpu_wr_data_i;
  logic      cpu_rd_valid_i;
  mem_addr_t cpu_rd_addr_i;
  logic      mc_wr_valid_o;
  mem_addr_t mc_wr_addr_o;
  mem_data_t mc_wr_data_o;
  logic      mc_rd_valid_o;
  mem_addr_t mc_rd_addr_o;
  logic      infl_irq_o;
  logic      defl_irq_o;
  logic      dump_mem_o;

  step_t steps[$];

  // Reference model state
  logic [`HACD_NUM_PAGES-1:0] used_m;
  int unsigned                free_m;
  logic                       pend_m;
  reg_data_t                  ctrl_m;
  reg_data_t                  wm_m;
  logic                       dump_m;

  // Items sent last cycle and due on the memory side now
  logic      prev_wr_valid;
  mem_wr_t   prev_wr;
  logic      prev_rd_valid;
  mem_addr_t prev_rd;

  logic        dump_seen;

  hacd hacd_inst (.*);

  always #50 clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Simulation FAILED");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic check_reg(input reg_data_t got, input reg_data_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_mem_wr(input mem_wr_t got, input mem_wr_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %h/%h expected %h/%h", $time, what,
                         got.addr, got.data, exp.addr, exp.data));
    end
  endtask

  task automatic check_addr(input mem_addr_t got, input mem_addr_t exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      stop_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // One clock cycle of drive, sample and model update
  //////////////////////////////////////////////////////////////////////

  task automatic run_cycle(input step_t s);
    mem_addr_t off;
    mem_wr_t   got_wr;
    page_idx_t wr_page;
    page_idx_t rd_page;
    logic      miss;
    logic      ctrl_we;
    @(posedge clk_i);
    #10;
    // Word-aligned offset inside the page
    off            = $urandom & ((32'h1 << `HACD_PAGE_SHIFT) - 32'h4);
    reg_valid_i    = 1'b0;
    reg_write_i    = 1'b0;
    reg_addr_i     = '0;
    reg_wdata_i    = '0;
    cpu_wr_valid_i = 1'b0;
    cpu_wr_addr_i  = '0;
    cpu_wr_data_i  = '0;
    cpu_rd_valid_i = 1'b0;
    cpu_rd_addr_i  = '0;
    case (s.op)
      OP_REG_WR, OP_DUMP: begin
        reg_valid_i = 1'b1;
        reg_write_i = 1'b1;
        reg_addr_i  = s.addr;
        reg_wdata_i = s.data;
      end
      OP_REG_RD: begin
        reg_valid_i = 1'b1;
        reg_addr_i  = s.addr;
      end
      OP_CPU_WR: begin
        cpu_wr_valid_i = 1'b1;
        cpu_wr_addr_i  = s.addr | off;
        cpu_wr_data_i  = $urandom;
      end
      OP_CPU_RD: begin
        cpu_rd_valid_i = 1'b1;
        cpu_rd_addr_i  = s.addr | off;
      end
      default: ;
    endcase
    // Sample late in the cycle when all outputs have settled
    #80;
    check_bit(mc_wr_valid_o, prev_wr_valid, "write channel valid");
    if (prev_wr_valid) begin
      got_wr.addr = mc_wr_addr_o;
      got_wr.data = mc_wr_data_o;
      check_mem_wr(got_wr, prev_wr, "write channel payload");
    end
    check_bit(mc_rd_valid_o, prev_rd_valid, "read channel valid");
    if (prev_rd_valid) begin
      check_addr(mc_rd_addr_o, prev_rd, "read channel address");
    end
    check_bit(reg_error_o, s.err, "register bus error");
    if (s.op == OP_REG_RD && !s.err) begin
      check_reg(reg_rdata_o, s.exp, $sformatf("register read at %h", s.addr));
    end
    check_bit(defl_irq_o, ctrl_m[CTRL_DEFL_EN] & (free_m < wm_m), "deflate interrupt");
    check_bit(infl_irq_o, ctrl_m[CTRL_INFL_EN] & pend_m, "inflate interrupt");
    check_bit(dump_mem_o, dump_m, "dump request");
    dump_seen = dump_mem_o;

    // Model the clock edge that ends this cycle
    wr_page = cpu_wr_addr_i[`HACD_PAGE_SHIFT +: `HACD_PAGE_IDX_W];
    rd_page = cpu_rd_addr_i[`HACD_PAGE_SHIFT +: `HACD_PAGE_IDX_W];
    miss    = cpu_rd_valid_i & ~used_m[rd_page];
    ctrl_we = reg_valid_i & reg_write_i & (reg_addr_i == OFS_CTRL);
    if (dump_m) begin
      used_m = '0;
      free_m = `HACD_NUM_PAGES;
    end else if (cpu_wr_valid_i && !used_m[wr_page]) begin
      used_m[wr_page] = 1'b1;
      free_m          = free_m - 1;
    end
    // Set wins over clear
    if (miss) begin
      pend_m = 1'b1;
    end else if (reg_valid_i && reg_write_i && reg_addr_i == OFS_STATUS &&
                 reg_wdata_i[STAT_INFL_BIT]) begin
      pend_m = 1'b0;
    end
    dump_m = ctrl_we & reg_wdata_i[CTRL_DUMP];
    if (ctrl_we) begin
      ctrl_m            = reg_wdata_i;
      ctrl_m[CTRL_DUMP] = 1'b0;
    end
    if (reg_valid_i && reg_write_i && reg_addr_i == OFS_LOW_WM) begin
      wm_m = reg_wdata_i;
    end
    prev_wr_valid = cpu_wr_valid_i;
    prev_wr.addr  = cpu_wr_addr_i;
    prev_wr.data  = cpu_wr_data_i;
    prev_rd_valid = cpu_rd_valid_i;
    prev_rd       = cpu_rd_addr_i;
  endtask

  // Bounded wait for the dump pulse and one more cycle to see it drop
  task automatic wait_for_dump();
    step_t       idle;
    int unsigned n;
    idle      = '0;
    dump_seen = 1'b0;
    n         = 0;
    while (!dump_seen && n < DUMP_WAIT_MAX) begin
      run_cycle(idle);
      n++;
    end
    if (!dump_seen) begin
      stop_run("Timeout: dump_mem_o never pulsed after the dump command");
    end
    run_cycle(idle);
  endtask

  task automatic add_step(input logic [2:0] op, input reg_addr_t addr, input reg_data_t data,
                          input reg_data_t exp, input logic err);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.data = data;
    s.exp  = exp;
    s.err  = err;
    steps.push_back(s);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////////////////////////

  task automatic build_table();
    // Reset values and read-back of control and watermark
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0000_0010, 1'b0);
    add_step(OP_REG_WR, OFS_CTRL, 32'h3, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_CTRL, 32'h0, 32'h3, 1'b0);
    add_step(OP_REG_WR, OFS_LOW_WM, 32'd12, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_LOW_WM, 32'h0, 32'd12, 1'b0);
    // Unmapped offset leaves everything unchanged
    add_step(OP_REG_WR, 32'hC, 32'hFFFF_FFFF, 32'h0, 1'b1);
    add_step(OP_REG_RD, 32'hC, 32'h0, 32'h0, 1'b1);
    add_step(OP_REG_RD, OFS_CTRL, 32'h0, 32'h3, 1'b0);
    add_step(OP_REG_RD, OFS_LOW_WM, 32'h0, 32'd12, 1'b0);
    // Back-to-back traffic with three new pages and one repeat
    add_step(OP_CPU_WR, 32'h0000_0000, 32'h0, 32'h0, 1'b0);
    add_step(OP_CPU_WR, 32'h0000_1000, 32'h0, 32'h0, 1'b0);
    add_step(OP_CPU_WR, 32'h0000_2000, 32'h0, 32'h0, 1'b0);
    add_step(OP_CPU_WR, 32'h0000_1000, 32'h0, 32'h0, 1'b0);
    add_step(OP_CPU_RD, 32'h0000_0000, 32'h0, 32'h0, 1'b0);
    add_step(OP_CPU_RD, 32'h0000_1000, 32'h0, 32'h0, 1'b0);
    add_step(OP_IDLE, 32'h0, 32'h0, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0000_000D, 1'b0);
    // Upper address bits ignored so this is page 2 again
    add_step(OP_CPU_WR, 32'h8000_2000, 32'h0, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0000_000D, 1'b0);
    // Deflate around watermark 12
    add_step(OP_CPU_WR, 32'h0000_3000, 32'h0, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0000_000C, 1'b0);
    add_step(OP_CPU_WR, 32'h0000_4000, 32'h0, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0000_000B, 1'b0);
    add_step(OP_REG_WR, OFS_CTRL, 32'h1, 32'h0, 1'b0);
    add_step(OP_REG_WR, OFS_CTRL, 32'h3, 32'h0, 1'b0);
    // Inflate miss and clear
    add_step(OP_CPU_RD, 32'h0000_9000, 32'h0, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0001_000B, 1'b0);
    add_step(OP_REG_WR, OFS_STATUS, 32'h0001_0000, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0000_000B, 1'b0);
    // Flag pending with the enable off
    add_step(OP_REG_WR, OFS_CTRL, 32'h2, 32'h0, 1'b0);
    add_step(OP_CPU_RD, 32'h0000_A000, 32'h0, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0001_000B, 1'b0);
    add_step(OP_REG_WR, OFS_CTRL, 32'h3, 32'h0, 1'b0);
    add_step(OP_REG_WR, OFS_STATUS, 32'h0001_0000, 32'h0, 1'b0);
    // Dump bit reads back 0 and all pages are free again
    add_step(OP_DUMP, OFS_CTRL, 32'h7, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_CTRL, 32'h0, 32'h3, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0000_0010, 1'b0);
    add_step(OP_CPU_RD, 32'h0000_0000, 32'h0, 32'h0, 1'b0);
    add_step(OP_REG_RD, OFS_STATUS, 32'h0, 32'h0001_0010, 1'b0);
    add_step(OP_REG_WR, OFS_STATUS, 32'h0001_0000, 32'h0, 1'b0);
    add_step(OP_IDLE, 32'h0, 32'h0, 32'h0, 1'b0);
    add_step(OP_IDLE, 32'h0, 32'h0, 32'h0, 1'b0);
  endtask

  initial begin
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    reg_valid_i    = 1'b0;
    reg_write_i    = 1'b0;
    reg_addr_i     = '0;
    reg_wdata_i    = '0;
    cpu_wr_valid_i = 1'b0;
    cpu_wr_addr_i  = '0;
    cpu_wr_data_i  = '0;
    cpu_rd_valid_i = 1'b0;
    cpu_rd_addr_i  = '0;
    // Model starts in the reset state
    used_m         = '0;
    free_m         = `HACD_NUM_PAGES;
    pend_m         = 1'b0;
    ctrl_m         = '0;
    wm_m           = '0;
    dump_m         = 1'b0;
    prev_wr_valid  = 1'b0;
    prev_wr        = '0;
    prev_rd_valid  = 1'b0;
    prev_rd        = '0;
    dump_seen      = 1'b0;
    void'($urandom(56848));
    build_table();
    repeat (2) @(posedge clk_i);
    #10;
    rst_ni = 1'b1;
    foreach (steps[i]) begin
      run_cycle(steps[i]);
      if (steps[i].op == OP_DUMP) begin
        wait_for_dump();
      end
    end
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: sources.f
+incdir+hw
hw/hacd_reg_pkg.sv
hw/hacd_mem_pkg.sv
hw/hacd_regs.sv
hw/hacd_page_tracker.sv
hw/hacd_fwd_stage.sv
hw/hacd_core.sv
hw/hacd.sv
verification/hacd_tb.sv

// File: Makefile
# Verilator build and run of the accelerator testbench
TOOL     = verilator
FLAGS    = --binary --timing
TOP      = hacd_tb
FILELIST = sources.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	@grep -q "Simulation PASSED" $(LOG) || (echo "test: pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
